/* logic/spi_slave_pkg.sv */
/*
 * SPI slave bridge shared definitions
 * widths, command state encoding, protocol constants and the
 * burst length lookup tables used by the memory reader
 */

package spi_slave_pkg;

  // widths that carry a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  reg_addr_t;
  typedef logic [16:0] burst_len_t;
  typedef logic [4:0]  edge_cnt_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_ADDR,
    ST_REG_WR,
    ST_REG_RD,
    ST_MEM_MODE,
    ST_MEM_RD,
    ST_WAIT_DESELECT
  } cmd_state_t;

  // ----------------------------------------
  // protocol constants
  // ----------------------------------------
  localparam logic [6:0] CMD_PREFIX     = 7'b0111010;
  localparam byte_t      DUMMY_BYTE     = 8'h55;
  localparam edge_cnt_t  EDGES_PER_BYTE = 5'd16;

  // lines per block, indexed by block size
  localparam logic [8:0] BLOCK_LINES [0:7] = '{
    9'd36, 9'd72, 9'd144, 9'd288, 9'd54, 9'd108, 9'd216, 9'd432
  };

  // depth per RS mode
  localparam logic [7:0] RS_DEPTH [0:3] = '{8'd240, 8'd224, 8'd192, 8'd176};

endpackage

/* logic/spi_edge_sync.sv */
/*
 * SPI front end
 * brings SS, SCK and MOSI into the clk_i domain and turns the
 * SCK transitions into shift and sample enables per CPOL/CPHA
 */

`timescale 1ns/10ps

module spi_edge_sync (
  input  logic clk_i,
  input  logic rstb_i,
  input  logic ss_i,
  input  logic sck_i,
  input  logic mosi_i,
  input  logic cpol_i,
  input  logic cpha_i,
  output logic sel_n_o,
  output logic mosi_s_o,
  output logic shift_en_o,
  output logic sample_en_o
);

  logic sck_pol;
  logic ss_d1;
  logic ss_d2;
  logic sck_d1;
  logic sck_d2;
  logic sck_d3;
  logic mosi_d1;
  logic mosi_d2;
  logic sck_rise;
  logic sck_fall;

  // normalize so that the leading edge is always a rising one
  assign sck_pol = cpol_i ? ~sck_i : sck_i;

  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
    begin
      ss_d1   <= 1'b1;
      ss_d2   <= 1'b1;
      sck_d1  <= 1'b0;
      sck_d2  <= 1'b0;
      sck_d3  <= 1'b0;
      mosi_d1 <= 1'b0;
      mosi_d2 <= 1'b0;
    end
    else
    begin
      ss_d1   <= ss_i;
      ss_d2   <= ss_d1;
      sck_d1  <= sck_pol;
      sck_d2  <= sck_d1;
      // history flop for edge detect
      sck_d3  <= sck_d2;
      mosi_d1 <= mosi_i;
      mosi_d2 <= mosi_d1;
    end
  end

  assign sck_rise = sck_d2 & ~sck_d3;
  assign sck_fall = ~sck_d2 & sck_d3;

  // cpha=0 samples on the leading edge, cpha=1 on the trailing one
  assign shift_en_o  = cpha_i ? sck_rise : sck_fall;
  assign sample_en_o = cpha_i ? sck_fall : sck_rise;

  assign sel_n_o  = ss_d2;
  assign mosi_s_o = mosi_d2;

endmodule

/* logic/spi_byte_shifter.sv */
/*
 * SPI byte framing
 * counts SCK edges into bytes and holds the receive and
 * transmit shift registers, MSB-first or LSB-first
 */

`timescale 1ns/10ps

module spi_byte_shifter (
  input  logic                 clk_i,
  input  logic                 rstb_i,
  input  logic                 sel_n_i,
  input  logic                 shift_en_i,
  input  logic                 sample_en_i,
  input  logic                 mosi_s_i,
  input  logic                 lsbf_i,
  input  logic                 rx_enable_i,
  input  logic                 tx_shift_enable_i,
  input  logic                 tx_load_i,
  input  spi_slave_pkg::byte_t tx_load_data_i,
  output logic                 byte_end_o,
  output spi_slave_pkg::byte_t rx_byte_o,
  output logic                 miso_o
);

  import spi_slave_pkg::*;

  edge_cnt_t edge_cnt;
  byte_t     rx_shift;
  byte_t     tx_shift;
  byte_t     tx_aligned;
  logic      tx_rotate;

  // ----------------------------------------
  // edge counter
  // ----------------------------------------
  assign byte_end_o = (edge_cnt == EDGES_PER_BYTE);

  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
      edge_cnt <= '0;
    else if (sel_n_i || byte_end_o)
      edge_cnt <= '0;
    else if (shift_en_i || sample_en_i)
      edge_cnt <= edge_cnt + 5'd1;
  end

  // ----------------------------------------
  // receive path
  // ----------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (rx_enable_i && sample_en_i)
    begin
      if (lsbf_i)
        rx_shift <= {mosi_s_i, rx_shift[7:1]};
      else
        rx_shift <= {rx_shift[6:0], mosi_s_i};
    end
  end

  assign rx_byte_o = rx_shift;

  // ----------------------------------------
  // transmit path
  // ----------------------------------------
  // lsb-first rotates right, so bit 0 has to start in the MSB
  assign tx_aligned = lsbf_i ? {tx_load_data_i[0], tx_load_data_i[7:1]} : tx_load_data_i;

  // with cpha=1 the very first edge is a shift edge;
  // skip it so the first bit stays on MISO for the first sample
  assign tx_rotate = tx_shift_enable_i && shift_en_i && (edge_cnt != '0);

  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
      tx_shift <= '0;
    else if (tx_load_i)
      tx_shift <= tx_aligned;
    else if (tx_rotate)
    begin
      if (lsbf_i)
        tx_shift <= {tx_shift[0], tx_shift[7:1]};
      else
        tx_shift <= {tx_shift[6:0], tx_shift[7]};
    end
  end

  assign miso_o = tx_shift[7];

endmodule

/* logic/spi_cmd_fsm.sv */
/*
 * SPI command decoder
 * parses prefix and address bytes, strobes register accesses
 * and selects what the transmit register loads at each byte end
 */

`timescale 1ns/10ps

module spi_cmd_fsm (
  input  logic                     clk_i,
  input  logic                     rstb_i,
  input  logic                     sel_n_i,
  input  logic                     byte_end_i,
  input  logic                     burst_done_i,
  input  spi_slave_pkg::byte_t     rx_byte_i,
  input  spi_slave_pkg::byte_t     reg_rdata_i,
  input  spi_slave_pkg::byte_t     mem_byte_i,
  output spi_slave_pkg::reg_addr_t reg_addr_o,
  output spi_slave_pkg::byte_t     reg_wdata_o,
  output logic                     reg_wr_o,
  output logic                     reg_rd_o,
  output logic                     rx_enable_o,
  output logic                     tx_shift_enable_o,
  output logic                     tx_load_o,
  output spi_slave_pkg::byte_t     tx_load_data_o,
  output logic                     mode_load_o,
  output logic                     mem_active_o
);

  import spi_slave_pkg::*;

  cmd_state_t state;
  cmd_state_t state_nxt;
  logic       is_prefix;
  logic       rd_done;
  logic       load_dummy;
  logic       load_reg;
  logic       load_mem;

  // top 7 bits prefix, bit 0 selects memory burst
  assign is_prefix = (rx_byte_i[7:1] == CMD_PREFIX);

  // ----------------------------------------
  // state register and next state
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    if (sel_n_i)
      state_nxt = ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
          state_nxt = ST_CMD;
        ST_CMD:
          if (byte_end_i)
          begin
            if (!is_prefix)
              state_nxt = ST_WAIT_DESELECT;
            else if (rx_byte_i[0])
              state_nxt = ST_MEM_MODE;
            else
              state_nxt = ST_ADDR;
          end
        ST_ADDR:
          if (byte_end_i)
            state_nxt = rx_byte_i[7] ? ST_REG_WR : ST_REG_RD;
        ST_REG_WR:
          if (byte_end_i)
            state_nxt = ST_WAIT_DESELECT;
        // one byte of dummy, one byte of register data
        ST_REG_RD:
          if (byte_end_i && rd_done)
            state_nxt = ST_WAIT_DESELECT;
        ST_MEM_MODE:
          if (byte_end_i)
            state_nxt = ST_MEM_RD;
        ST_MEM_RD:
          if (byte_end_i && burst_done_i)
            state_nxt = ST_WAIT_DESELECT;
        ST_WAIT_DESELECT:
          state_nxt = ST_WAIT_DESELECT;
        default:
          state_nxt = ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // register access
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
    begin
      reg_addr_o  <= '0;
      reg_wdata_o <= '0;
      reg_wr_o    <= 1'b0;
      reg_rd_o    <= 1'b0;
    end
    else
    begin
      if (state == ST_ADDR && byte_end_i)
        reg_addr_o <= rx_byte_i[6:0];
      if (state == ST_REG_WR && byte_end_i)
        reg_wdata_o <= rx_byte_i;
      reg_wr_o <= (state == ST_REG_WR) && byte_end_i;
      reg_rd_o <= (state == ST_ADDR) && byte_end_i && !rx_byte_i[7];
    end
  end

  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
      rd_done <= 1'b0;
    else if (state != ST_REG_RD)
      rd_done <= 1'b0;
    else if (load_reg)
      rd_done <= 1'b1;
  end

  // ----------------------------------------
  // transmit load selection
  // ----------------------------------------
  assign load_dummy = byte_end_i && ((state == ST_ADDR && !rx_byte_i[7]) ||
                                     state == ST_MEM_MODE);
  assign load_reg   = byte_end_i && (state == ST_REG_RD) && !rd_done;
  assign load_mem   = byte_end_i && (state == ST_MEM_RD);

  assign tx_load_o = load_dummy || load_reg || load_mem;

  always_comb
  begin
    if (load_reg)
      tx_load_data_o = reg_rdata_i;
    else if (load_mem)
      tx_load_data_o = mem_byte_i;
    else
      tx_load_data_o = DUMMY_BYTE;
  end

  assign rx_enable_o = (state == ST_CMD) || (state == ST_ADDR) ||
                       (state == ST_REG_WR) || (state == ST_MEM_MODE);
  assign tx_shift_enable_o = (state == ST_REG_RD) || (state == ST_MEM_RD);

  assign mode_load_o  = (state == ST_MEM_MODE) && byte_end_i;
  assign mem_active_o = (state == ST_MEM_RD);

endmodule

/* logic/mem_burst_reader.sv */
/*
 * memory burst reader
 * decodes the mode byte into a burst length and paces the
 * memory read strobes against the SPI byte ends
 */

`timescale 1ns/10ps

module mem_burst_reader (
  input  logic                 clk_i,
  input  logic                 rstb_i,
  input  logic                 sel_n_i,
  input  logic                 byte_end_i,
  input  logic                 mode_load_i,
  input  logic                 mem_active_i,
  input  logic                 mem_valid_i,
  input  spi_slave_pkg::byte_t rx_byte_i,
  input  spi_slave_pkg::byte_t mem_rdata_i,
  output logic                 mem_rd_o,
  output logic                 burst_done_o,
  output spi_slave_pkg::byte_t mem_byte_o
);

  import spi_slave_pkg::*;

  logic [2:0] block_size;
  logic [1:0] rs_mode;
  burst_len_t burst_len;
  burst_len_t rd_cnt;
  logic       at_len;
  logic       data_back;
  logic       next_req;

  // ----------------------------------------
  // mode decode
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
    begin
      block_size <= '0;
      rs_mode    <= '0;
    end
    else if (mode_load_i)
    begin
      block_size <= rx_byte_i[6:4];
      rs_mode    <= rx_byte_i[3:2];
    end
  end

  assign burst_len = burst_len_t'(BLOCK_LINES[block_size]) * burst_len_t'(RS_DEPTH[rs_mode]);
  assign at_len    = (rd_cnt == burst_len);

  // ----------------------------------------
  // read strobes
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
    begin
      rd_cnt    <= '0;
      next_req  <= 1'b0;
      mem_rd_o  <= 1'b0;
      data_back <= 1'b0;
    end
    else
    begin
      if (sel_n_i || mode_load_i)
        rd_cnt <= '0;
      else if (mem_rd_o)
        rd_cnt <= rd_cnt + 17'd1;
      // next request only once the previous data is in
      next_req <= byte_end_i && mem_active_i && data_back && !at_len && !sel_n_i;
      mem_rd_o <= (mode_load_i || next_req) && !sel_n_i;
      if (mode_load_i || next_req)
        data_back <= 1'b0;
      else if (mem_valid_i)
        data_back <= 1'b1;
    end
  end

  // set at the byte end that loads the last datum, held until next burst
  always_ff @(posedge clk_i or negedge rstb_i)
  begin
    if (!rstb_i)
      burst_done_o <= 1'b0;
    else if (mode_load_i)
      burst_done_o <= 1'b0;
    else if (sel_n_i || (byte_end_i && mem_active_i && at_len))
      burst_done_o <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_valid_i)
      mem_byte_o <= mem_rdata_i;
  end

endmodule

/* logic/spi_slave_top.sv */
/*
 * SPI slave bridge top level
 * front end, byte shifter, command FSM and memory burst reader
 */

`timescale 1ns/10ps

module spi_slave_top (
  input  logic                     clk_i,
  input  logic                     rstb_i,
  input  logic                     ss_i,
  input  logic                     sck_i,
  input  logic                     mosi_i,
  input  logic                     cpol_i,
  input  logic                     cpha_i,
  input  logic                     lsbf_i,
  input  logic                     mem_valid_i,
  input  spi_slave_pkg::byte_t     reg_rdata_i,
  input  spi_slave_pkg::byte_t     mem_rdata_i,
  output logic                     miso_o,
  output logic                     reg_wr_o,
  output logic                     reg_rd_o,
  output logic                     mem_rd_o,
  output spi_slave_pkg::reg_addr_t reg_addr_o,
  output spi_slave_pkg::byte_t     reg_wdata_o
);

  import spi_slave_pkg::*;

  logic  sel_n;
  logic  mosi_s;
  logic  shift_en;
  logic  sample_en;
  logic  byte_end;
  byte_t rx_byte;
  logic  rx_enable;
  logic  tx_shift_enable;
  logic  tx_load;
  byte_t tx_load_data;
  logic  mode_load;
  logic  mem_active;
  byte_t mem_byte;
  logic  burst_done;

  spi_edge_sync u_edge_sync (
    .clk_i       (clk_i),
    .rstb_i      (rstb_i),
    .ss_i        (ss_i),
    .sck_i       (sck_i),
    .mosi_i      (mosi_i),
    .cpol_i      (cpol_i),
    .cpha_i      (cpha_i),
    .sel_n_o     (sel_n),
    .mosi_s_o    (mosi_s),
    .shift_en_o  (shift_en),
    .sample_en_o (sample_en)
  );

  spi_byte_shifter u_byte_shifter (
    .clk_i             (clk_i),
    .rstb_i            (rstb_i),
    .sel_n_i           (sel_n),
    .shift_en_i        (shift_en),
    .sample_en_i       (sample_en),
    .mosi_s_i          (mosi_s),
    .lsbf_i            (lsbf_i),
    .rx_enable_i       (rx_enable),
    .tx_shift_enable_i (tx_shift_enable),
    .tx_load_i         (tx_load),
    .tx_load_data_i    (tx_load_data),
    .byte_end_o        (byte_end),
    .rx_byte_o         (rx_byte),
    .miso_o            (miso_o)
  );

  spi_cmd_fsm u_cmd_fsm (
    .clk_i             (clk_i),
    .rstb_i            (rstb_i),
    .sel_n_i           (sel_n),
    .byte_end_i        (byte_end),
    .burst_done_i      (burst_done),
    .rx_byte_i         (rx_byte),
    .reg_rdata_i       (reg_rdata_i),
    .mem_byte_i        (mem_byte),
    .reg_addr_o        (reg_addr_o),
    .reg_wdata_o       (reg_wdata_o),
    .reg_wr_o          (reg_wr_o),
    .reg_rd_o          (reg_rd_o),
    .rx_enable_o       (rx_enable),
    .tx_shift_enable_o (tx_shift_enable),
    .tx_load_o         (tx_load),
    .tx_load_data_o    (tx_load_data),
    .mode_load_o       (mode_load),
    .mem_active_o      (mem_active)
  );

  mem_burst_reader u_burst_reader (
    .clk_i        (clk_i),
    .rstb_i       (rstb_i),
    .sel_n_i      (sel_n),
    .byte_end_i   (byte_end),
    .mode_load_i  (mode_load),
    .mem_active_i (mem_active),
    .mem_valid_i  (mem_valid_i),
    .rx_byte_i    (rx_byte),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rd_o     (mem_rd_o),
    .burst_done_o (burst_done),
    .mem_byte_o   (mem_byte)
  );

endmodule

/* sim/tb_spi_slave.sv */
/*
 * SPI slave bridge testbench
 * SPI master, register bank and memory models around the DUT;
 * transactions and expected values come from the golden file
 */

`timescale 1ns/10ps

module tb_spi_slave;

  import spi_slave_pkg::*;

  localparam int REC_WORDS = 10;
  localparam int MAX_RECS  = 32;
  localparam int HALF_SCK  = 4;
  localparam int BYTE_GAP  = 8;

  logic      clk_i       = 1'b0;
  logic      rstb_i      = 1'b0;
  logic      ss_i        = 1'b1;
  logic      sck_i       = 1'b0;
  logic      mosi_i      = 1'b0;
  logic      cpol_i      = 1'b0;
  logic      cpha_i      = 1'b0;
  logic      lsbf_i      = 1'b0;
  logic      mem_valid_i = 1'b0;
  byte_t     reg_rdata_i = '0;
  byte_t     mem_rdata_i = '0;
  logic      miso_o;
  logic      reg_wr_o;
  logic      reg_rd_o;
  logic      mem_rd_o;
  reg_addr_t reg_addr_o;
  byte_t     reg_wdata_o;

  logic [31:0] golden [0:REC_WORDS*MAX_RECS-1];
  byte_t       reg_bank [0:127];
  int          wr_cnt       = 0;
  int          rd_cnt       = 0;
  int          strobe_cnt   = 0;
  reg_addr_t   last_wr_addr = '0;
  byte_t       last_wr_data = '0;
  byte_t       pend_data    = '0;
  logic [2:0]  valid_pipe   = '0;
  int          cycle_cnt    = 0;
  int          cycle_limit  = 0;
  byte_t       tx_bytes [$];
  byte_t       rx_bytes [$];

  spi_slave_top uut (
    .clk_i       (clk_i),
    .rstb_i      (rstb_i),
    .ss_i        (ss_i),
    .sck_i       (sck_i),
    .mosi_i      (mosi_i),
    .cpol_i      (cpol_i),
    .cpha_i      (cpha_i),
    .lsbf_i      (lsbf_i),
    .mem_valid_i (mem_valid_i),
    .reg_rdata_i (reg_rdata_i),
    .mem_rdata_i (mem_rdata_i),
    .miso_o      (miso_o),
    .reg_wr_o    (reg_wr_o),
    .reg_rd_o    (reg_rd_o),
    .mem_rd_o    (mem_rd_o),
    .reg_addr_o  (reg_addr_o),
    .reg_wdata_o (reg_wdata_o)
  );

  always #2 clk_i = ~clk_i;

  // ----------------------------------------
  // register bank and memory models
  // ----------------------------------------
  always @(posedge clk_i)
  begin
    if (!rstb_i)
    begin
      for (int i = 0; i < 128; i++)
        reg_bank[i] <= 8'(i) ^ 8'hA5;
      wr_cnt <= 0;
      rd_cnt <= 0;
    end
    else
    begin
      if (reg_wr_o)
      begin
        reg_bank[reg_addr_o] <= reg_wdata_o;
        last_wr_addr         <= reg_addr_o;
        last_wr_data         <= reg_wdata_o;
        wr_cnt               <= wr_cnt + 1;
      end
      if (reg_rd_o)
        rd_cnt <= rd_cnt + 1;
    end
    reg_rdata_i <= reg_bank[reg_addr_o];
  end

  // answers each strobe 3 cycles later with the running strobe count
  always @(posedge clk_i)
  begin
    if (!rstb_i)
    begin
      strobe_cnt  <= 0;
      valid_pipe  <= '0;
      mem_valid_i <= 1'b0;
    end
    else
    begin
      valid_pipe  <= {valid_pipe[1:0], mem_rd_o};
      mem_valid_i <= valid_pipe[1];
      if (mem_rd_o)
      begin
        pend_data  <= strobe_cnt[7:0];
        strobe_cnt <= strobe_cnt + 1;
      end
      if (valid_pipe[1])
        mem_rdata_i <= pend_data;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("TB FAILED");
      $fatal(1, "timeout: run went past %0d cycles", cycle_limit);
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] golden_field(input int rec, input int col);
    return golden[rec * REC_WORDS + col];
  endfunction

  function automatic bit op_known(input logic [31:0] op);
    return (op === 32'h57) || (op === 32'h52) || (op === 32'h4D) || (op === 32'h42);
  endfunction

  function automatic int record_bytes(input int rec);
    logic [31:0] op;
    op = golden_field(rec, 0);
    if (op == 32'h52)
      return 4;
    else if (op == 32'h4D)
      return 2 + int'(golden_field(rec, 7));
    else
      return 3;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // SPI master that sends tx_bytes and collects MISO into rx_bytes
  task automatic spi_transfer(input logic cpol, input logic cpha, input logic lsbf);
    byte_t      rx;
    logic [2:0] bit_idx;
    rx_bytes.delete();
    @(posedge clk_i);
    cpol_i <= cpol;
    cpha_i <= cpha;
    lsbf_i <= lsbf;
    sck_i  <= cpol;
    repeat (8) @(posedge clk_i);
    ss_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    foreach (tx_bytes[n])
    begin
      rx = '0;
      for (int i = 0; i < 8; i++)
      begin
        bit_idx = lsbf ? 3'(i) : 3'(7 - i);
        if (!cpha)
          mosi_i <= tx_bytes[n][bit_idx];
        repeat (HALF_SCK) @(posedge clk_i);
        sck_i <= ~cpol;
        if (cpha)
          mosi_i <= tx_bytes[n][bit_idx];
        else
          rx[bit_idx] = miso_o;
        repeat (HALF_SCK) @(posedge clk_i);
        sck_i <= cpol;
        if (cpha)
          rx[bit_idx] = miso_o;
      end
      rx_bytes.push_back(rx);
      repeat (BYTE_GAP) @(posedge clk_i);
    end
    ss_i <= 1'b1;
    repeat (12) @(posedge clk_i);
  endtask

  // ----------------------------------------
  // one golden record
  // ----------------------------------------
  task automatic run_record(input int rec);
    logic [31:0] op;
    byte_t       b2;
    int          n;
    logic [31:0] e0;
    logic [31:0] e1;
    int          wr0;
    int          rd0;
    int          st0;
    int          nchk;
    byte_t       exp_byte;
    op  = golden_field(rec, 0);
    b2  = 8'(golden_field(rec, 6));
    n   = int'(golden_field(rec, 7));
    e0  = golden_field(rec, 8);
    e1  = golden_field(rec, 9);
    wr0 = wr_cnt;
    rd0 = rd_cnt;
    st0 = strobe_cnt;
    tx_bytes.delete();
    tx_bytes.push_back(8'(golden_field(rec, 4)));
    tx_bytes.push_back(8'(golden_field(rec, 5)));
    if (op == 32'h4D)
    begin
      for (int i = 0; i < n; i++)
        tx_bytes.push_back(b2);
    end
    else
    begin
      tx_bytes.push_back(b2);
      if (op == 32'h52)
        tx_bytes.push_back(b2);
    end
    spi_transfer(1'(golden_field(rec, 1)), 1'(golden_field(rec, 2)),
                 1'(golden_field(rec, 3)));

    if (op == 32'h57)
    begin
      check_value("reg write count", 32'(wr_cnt - wr0), 32'd1);
      check_value("reg write address", 32'(last_wr_addr), e0);
      check_value("reg write data", 32'(last_wr_data), e1);
    end
    else
      check_value("reg write count", 32'(wr_cnt - wr0), 32'd0);

    if (op == 32'h52)
    begin
      check_value("reg read count", 32'(rd_cnt - rd0), 32'd1);
      check_value("reply byte", 32'(rx_bytes[2]), e0);
      check_value("reg read data", 32'(rx_bytes[3]), e1);
    end
    else
      check_value("reg read count", 32'(rd_cnt - rd0), 32'd0);

    if (op == 32'h4D)
    begin
      check_value("mem strobe count", 32'(strobe_cnt - st0), e1);
      // dummy byte first, then one byte per strobe
      nchk = (n <= int'(e1)) ? n : int'(e1) + 1;
      for (int j = 0; j < nchk; j++)
      begin
        exp_byte = (j == 0) ? 8'(e0) : 8'(st0 + j - 1);
        check_value("burst byte", 32'(rx_bytes[2 + j]), 32'(exp_byte));
      end
    end
    else
      check_value("mem strobe count", 32'(strobe_cnt - st0), 32'd0);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    int n_recs;
    int total_bytes;
    n_recs      = 0;
    total_bytes = 0;
    $readmemh("sim/spi_golden.txt", golden);
    while (n_recs < MAX_RECS && op_known(golden_field(n_recs, 0)))
    begin
      total_bytes = total_bytes + record_bytes(n_recs);
      n_recs      = n_recs + 1;
    end
    // 1.2 times the expected run length
    cycle_limit = (total_bytes * (16 * HALF_SCK + BYTE_GAP) + n_recs * 40 + 100) * 12 / 10;

    if (n_recs == 0)
    begin
      $display("TB FAILED");
      $fatal(1, "no transactions found in the golden file");
    end
    else
    begin
      repeat (16) @(posedge clk_i);
      rstb_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      for (int r = 0; r < n_recs; r++)
        run_record(r);
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

/* sim/spi_golden.txt */
// op cpol cpha lsbf byte0 byte1 byte2 fill_count exp0 exp1
// op: 57 reg write, 52 reg read, 4D memory burst, 42 bad command; 00 ends the list
57 0 0 0 74 85 3C 0 05 3C
52 0 0 0 74 05 00 0 55 3C
52 0 0 0 74 10 00 0 55 B5
57 0 1 0 74 92 C7 0 12 C7
52 0 1 0 74 12 00 0 55 C7
57 1 0 0 74 A0 5E 0 20 5E
52 1 0 0 74 20 00 0 55 5E
57 1 1 0 74 FF 81 0 7F 81
52 1 1 0 74 7F 00 0 55 81
57 0 0 1 74 83 E1 0 03 E1
52 0 0 1 74 03 00 0 55 E1
52 0 1 1 74 33 00 0 55 96
57 1 0 1 74 C4 2B 0 44 2B
52 1 1 1 74 44 00 0 55 2B
42 0 0 0 3A 85 11 0 00 00
52 0 0 0 74 05 00 0 55 3C
4D 0 0 0 75 00 00 6 55 7
4D 1 1 1 75 40 00 5 55 6
42 1 0 1 00 75 0C 0 00 00
4D 0 1 0 75 0C 00 18C3 55 18C0
57 0 0 0 74 8A 99 0 0A 99
52 0 0 0 74 0A 00 0 55 99
52 1 1 1 74 10 00 0 55 B5
00 0 0 0 00 00 00 0 00 00

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_spi_slave -f sources.f -o tb_spi_slave
./obj_dir/tb_spi_slave

/* sources.f */
logic/spi_slave_pkg.sv
logic/spi_edge_sync.sv
logic/spi_byte_shifter.sv
logic/spi_cmd_fsm.sv
logic/mem_burst_reader.sv
logic/spi_slave_top.sv
sim/tb_spi_slave.sv
